// ==== sim.f ====
source/bus_pkg.sv
source/display_pkg.sv
source/reset_sync.sv
source/bus_arbiter.sv
source/word_mem.sv
source/stream_regs.sv
source/frame_streamer.sv
source/spi_shifter.sv
source/spi_display_top.sv
sim/tb_spi_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spi_display
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
	  echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_spi_display.sv ====
`timescale 1ns/1ns

module tb_spi_display;

  localparam int bus_timeout   = 50;      // Cycles for one host access
  localparam int frame_timeout = 20000;

  logic              clk;
  logic              arst_n;
  bus_pkg::bus_req_t host_req;
  bus_pkg::bus_rsp_t host_rsp;
  logic              start;
  logic              busy;
  logic              done;
  logic              sck;
  logic              mosi;
  logic              cs_n;
  logic              dc;

  // Reference model of memory and registers
  bus_pkg::data_t      model_mem [bus_pkg::mem_words];
  bus_pkg::word_idx_t  model_base  = 10'd0;
  display_pkg::count_t model_count = 11'd0;
  display_pkg::div_t   model_div   = 8'd3;
  logic [8:0]          exp_items [$];   // {dc, data} per byte
  logic [8:0]          rx_items [$];
  int                  exp_div = 3;

  // SPI monitor state
  int         cycle         = 0;
  int         last_edge     = 0;
  int         rx_bits       = 0;
  int         done_count    = 0;
  int         cs_fall_count = 0;
  logic [7:0] rx_shift      = 8'd0;
  logic       rx_dc         = 1'b0;
  logic       prev_sck      = 1'b0;
  logic       prev_cs_n     = 1'b1;

  spi_display_top spi_display_top_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .sck      (sck),
    .mosi     (mosi),
    .cs_n     (cs_n),
    .dc       (dc)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // One host access under the req/ack rule from falling edge to falling edge
  task automatic bus_access(input logic write, input bus_pkg::addr_t addr,
                            input bus_pkg::data_t wdata, output bus_pkg::data_t rdata);
    int waited;
    waited         = 0;
    host_req.req   = 1'b1;
    host_req.write = write;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    @(negedge clk);
    while (!host_rsp.ack)
    begin
      waited++;
      if (waited > bus_timeout)
      begin
        $display("Host access to address %h was never acknowledged", addr);
        stop_with_failure();
      end
      @(negedge clk);
    end
    rdata    = host_rsp.rdata;
    host_req = '0;
    @(negedge clk);   // Req low for at least one edge
  endtask

  // Upper address bits are random but keep bit 28 clear
  function automatic bus_pkg::addr_t word_addr(input bus_pkg::word_idx_t idx);
    bus_pkg::addr_t a;
    a       = $urandom;
    a[28]   = 1'b0;
    a[11:2] = idx;
    return a;
  endfunction

  task automatic mem_write(input bus_pkg::word_idx_t idx, input bus_pkg::data_t wdata);
    bus_pkg::data_t rdata;
    bus_access(1'b1, word_addr(idx), wdata, rdata);
    model_mem[idx] = wdata;
  endtask

  task automatic mem_read_check(input bus_pkg::word_idx_t idx);
    bus_pkg::data_t rdata;
    bus_access(1'b0, word_addr(idx), '0, rdata);
    check_equal(rdata, model_mem[idx], $sformatf("memory word %0d", idx));
  endtask

  function automatic bus_pkg::data_t reg_model_value(input bus_pkg::addr_t off);
    bus_pkg::data_t v;
    v = '0;   // Unmapped offsets read zero
    case (off)
      bus_pkg::reg_base_addr:  v[9:0]  = model_base;
      bus_pkg::reg_count_addr: v[10:0] = model_count;
      bus_pkg::reg_div_addr:   v[7:0]  = model_div;
      default: ;
    endcase
    return v;
  endfunction

  task automatic reg_write(input bus_pkg::addr_t off, input bus_pkg::data_t wdata);
    bus_pkg::data_t rdata;
    bus_access(1'b1, bus_pkg::reg_base | off, wdata, rdata);
    case (off)
      bus_pkg::reg_base_addr:  model_base  = wdata[9:0];
      bus_pkg::reg_count_addr: model_count = wdata[10:0];
      bus_pkg::reg_div_addr:   model_div   = wdata[7:0];
      default: ;
    endcase
  endtask

  task automatic reg_read_check(input bus_pkg::addr_t off);
    bus_pkg::data_t rdata;
    bus_access(1'b0, bus_pkg::reg_base | off, '0, rdata);
    check_equal(rdata, reg_model_value(off), $sformatf("register at offset %h", off));
  endtask

  // Programs, starts and checks one frame with optional host traffic and a second start
  task automatic run_frame(input bus_pkg::word_idx_t base, input display_pkg::count_t count,
                           input display_pkg::div_t div, input logic share);
    int                 done_before;
    int                 waited;
    int                 k;
    bus_pkg::word_idx_t idx;
    reg_write(bus_pkg::reg_base_addr, bus_pkg::data_t'(base));
    reg_write(bus_pkg::reg_count_addr, bus_pkg::data_t'(count));
    reg_write(bus_pkg::reg_div_addr, bus_pkg::data_t'(div));
    exp_items.delete();
    rx_items.delete();
    for (int i = 0; i < int'(count); i++)
      exp_items.push_back(model_mem[bus_pkg::word_idx_t'(int'(base) + i)][8:0]);
    exp_div     = int'(div);
    done_before = done_count;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (share)
    begin
      check_equal(32'(busy), 32'd1, "busy after start");
      start = 1'b1;   // Must be ignored
      @(negedge clk);
      start = 1'b0;
      repeat (8)
      begin
        k   = int'($urandom_range(0, 1023 - int'(count)));
        idx = bus_pkg::word_idx_t'(int'(base) + int'(count) + k);   // Outside the frame
        mem_write(idx, $urandom);
        mem_read_check(idx);
        mem_read_check(bus_pkg::word_idx_t'($urandom_range(0, 1023)));
      end
      reg_read_check(bus_pkg::reg_count_addr);
    end
    waited = 0;
    while (done_count == done_before)
    begin
      waited++;
      if (waited > frame_timeout)
      begin
        $display("Frame of %0d items never signalled done", count);
        stop_with_failure();
      end
      @(negedge clk);
    end
    repeat (4) @(negedge clk);   // Catch stray pulses or bytes
    check_equal(done_count - done_before, 1, "done pulses per frame");
    check_equal(32'(busy), 32'd0, "busy after done");
    check_equal(rx_items.size(), exp_items.size(), "bytes per frame");
    foreach (exp_items[i])
      check_equal(32'(rx_items[i]), 32'(exp_items[i]), $sformatf("dc and byte %0d", i));
  endtask

  task automatic run_empty_frame();
    int falls;
    int waited;
    reg_write(bus_pkg::reg_count_addr, '0);
    rx_items.delete();
    falls = cs_fall_count;
    start = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    waited = 1;
    while (!done)
    begin
      if (waited > frame_timeout)
      begin
        $display("Empty frame never signalled done");
        stop_with_failure();
      end
      @(negedge clk);
      waited++;
    end
    check_equal(waited, 2, "cycles from start to done on an empty frame");
    repeat (4) @(negedge clk);
    check_equal(cs_fall_count - falls, 0, "cs_n activity on an empty frame");
    check_equal(rx_items.size(), 0, "bytes on an empty frame");
  endtask

  // SPI monitor sampling between clock edges where outputs are stable
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      cycle++;
      if (done)
        done_count++;
      if (prev_cs_n && !cs_n)
      begin
        cs_fall_count++;
        rx_dc     = dc;
        rx_bits   = 0;
        rx_shift  = 8'd0;
        last_edge = cycle;
      end
      else if (!cs_n && sck != prev_sck)
      begin
        check_equal(cycle - last_edge, exp_div + 1, "SCK half period in cycles");
        last_edge = cycle;
        if (sck)
        begin
          rx_shift = {rx_shift[6:0], mosi};   // MSB arrives first
          rx_bits++;
        end
      end
      else if (!prev_cs_n && cs_n)
      begin
        check_equal(cycle - last_edge, exp_div + 1, "last half period before cs_n rise");
        check_equal(rx_bits, 8, "SCK rising edges per byte");
        rx_items.push_back({rx_dc, rx_shift});
      end
      prev_sck  = sck;
      prev_cs_n = cs_n;
    end
  end

  initial
  begin
    bus_pkg::data_t rnd;
    bus_pkg::addr_t off;
    rnd      = $urandom(32'hd8463d6c);
    clk      = 1'b0;
    arst_n   = 1'b0;
    start    = 1'b0;
    host_req = '0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    repeat (4) @(negedge clk);   // Release chain
    check_equal(32'(cs_n), 32'd1, "cs_n after reset");
    check_equal(32'({sck, mosi, dc, busy, done, host_rsp.ack}), 32'd0, "outputs after reset");

    // Memory fill followed by random traffic
    for (int i = 0; i < bus_pkg::mem_words; i++)
      mem_write(bus_pkg::word_idx_t'(i), $urandom);
    repeat (300)
    begin
      rnd = $urandom;
      if (rnd[1:0] == 2'd0)
        mem_write(bus_pkg::word_idx_t'($urandom_range(0, 1023)), $urandom);
      else
        mem_read_check(bus_pkg::word_idx_t'($urandom_range(0, 1023)));
    end

    reg_read_check(bus_pkg::reg_base_addr);
    reg_read_check(bus_pkg::reg_count_addr);
    reg_read_check(bus_pkg::reg_div_addr);
    repeat (40)
    begin
      off = bus_pkg::addr_t'($urandom_range(0, 3) * 4);   // 0xC is unmapped
      reg_write(off, $urandom);
      reg_read_check(off);
    end

    repeat (8)
      run_frame(bus_pkg::word_idx_t'($urandom_range(0, 1023)),
                display_pkg::count_t'($urandom_range(1, 20)),
                display_pkg::div_t'($urandom_range(0, 9)), 1'b0);
    run_frame(10'd1015, 11'd20, 8'd0, 1'b0);   // Wraps past the last word
    run_frame(bus_pkg::word_idx_t'($urandom_range(0, 1023)), 11'd3, 8'd40, 1'b0);
    repeat (3)
      run_frame(bus_pkg::word_idx_t'($urandom_range(0, 1023)),
                display_pkg::count_t'($urandom_range(10, 20)),
                display_pkg::div_t'($urandom_range(4, 9)), 1'b1);
    run_empty_frame();

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== source/spi_display_top.sv ====
`timescale 1ns/1ns

module spi_display_top (
  input  logic              clk,
  input  logic              arst_n,
  input  bus_pkg::bus_req_t host_req,
  output bus_pkg::bus_rsp_t host_rsp,
  input  logic              start,
  output logic              busy,
  output logic              done,
  output logic              sck,
  output logic              mosi,
  output logic              cs_n,
  output logic              dc
);

  logic                     rst_n;
  bus_pkg::bus_req_t        strm_req;
  bus_pkg::bus_rsp_t        strm_rsp;
  bus_pkg::bus_req_t        mem_req;
  bus_pkg::bus_rsp_t        mem_rsp;
  bus_pkg::bus_req_t        reg_req;
  bus_pkg::bus_rsp_t        reg_rsp;
  display_pkg::stream_cfg_t cfg;
  display_pkg::disp_item_t  item;
  logic                     send;
  logic                     shift_busy;

  reset_sync reset_sync_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .rst_n  (rst_n)
  );

  bus_arbiter bus_arbiter_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .strm_req (strm_req),
    .strm_rsp (strm_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .reg_req  (reg_req),
    .reg_rsp  (reg_rsp)
  );

  word_mem word_mem_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

  stream_regs stream_regs_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (reg_req),
    .rsp   (reg_rsp),
    .cfg   (cfg)
  );

  frame_streamer frame_streamer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cfg        (cfg),
    .bus_req    (strm_req),
    .bus_rsp    (strm_rsp),
    .item       (item),
    .send       (send),
    .shift_busy (shift_busy),
    .busy       (busy),
    .done       (done)
  );

  // Divider comes straight from the registers, latched per byte
  spi_shifter spi_shifter_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .div   (cfg.div),
    .item  (item),
    .send  (send),
    .busy  (shift_busy),
    .sck   (sck),
    .mosi  (mosi),
    .cs_n  (cs_n),
    .dc    (dc)
  );

endmodule

// ==== source/spi_shifter.sv ====
`timescale 1ns/1ns

module spi_shifter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  display_pkg::div_t       div,
  input  display_pkg::disp_item_t item,
  input  logic                    send,
  output logic                    busy,
  output logic                    sck,
  output logic                    mosi,
  output logic                    cs_n,
  output logic                    dc
);

  display_pkg::div_t div_q;    // Held for the whole byte
  display_pkg::div_t cnt;      // Cycles into the current half period
  logic [3:0]        bits;     // Falling edges so far
  logic [7:0]        shreg;
  logic              active;
  logic              sck_q;
  logic              cs_n_q;
  logic              dc_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      sck_q  <= 1'b0;
      cs_n_q <= 1'b1;
      dc_q   <= 1'b0;
      shreg  <= '0;
      cnt    <= '0;
      bits   <= '0;
    end
    else if (!active)
    begin
      if (send)
      begin
        active <= 1'b1;
        cs_n_q <= 1'b0;         // Select and dc together
        dc_q   <= item.dc;
        shreg  <= item.data;
        cnt    <= '0;
        bits   <= '0;
      end
    end
    else if (cnt == div_q)
    begin
      cnt <= '0;
      if (sck_q)
      begin
        sck_q <= 1'b0;          // Falling edge moves the next bit out
        shreg <= {shreg[6:0], 1'b0};
        bits  <= bits + 1'b1;
      end
      else if (bits == 4'd8)
      begin
        active <= 1'b0;         // Trailing low half done
        cs_n_q <= 1'b1;
      end
      else
        sck_q <= 1'b1;
    end
    else
      cnt <= cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (send && !active)
      div_q <= div;
  end

  assign busy = active;
  assign sck  = sck_q;
  assign mosi = shreg[7];   // MSB first
  assign cs_n = cs_n_q;
  assign dc   = dc_q;

  a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sck);

endmodule

// ==== source/frame_streamer.sv ====
`timescale 1ns/1ns

module frame_streamer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  display_pkg::stream_cfg_t cfg,
  output bus_pkg::bus_req_t        bus_req,
  input  bus_pkg::bus_rsp_t        bus_rsp,
  output display_pkg::disp_item_t  item,
  output logic                     send,
  input  logic                     shift_busy,
  output logic                     busy,
  output logic                     done
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_wait_shift,
    st_finish
  } state_t;

  state_t                  state;
  bus_pkg::word_idx_t      addr_q;   // Next word to read, wraps with the memory
  display_pkg::count_t     left_q;   // Items not yet fetched
  display_pkg::disp_item_t item_q;
  logic                    done_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= st_idle;
      addr_q <= '0;
      left_q <= '0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        st_idle:
        begin
          if (start)
          begin
            addr_q <= cfg.base;
            left_q <= cfg.count;
            state  <= (cfg.count == '0) ? st_finish : st_fetch;
          end
        end
        st_fetch:
        begin
          if (bus_rsp.ack)
          begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
            state  <= st_wait_shift;
          end
        end
        st_wait_shift:
        begin
          // Prefetch the next word while this byte shifts out
          if (!shift_busy)
            state <= (left_q == '0) ? st_finish : st_fetch;
        end
        default:
        begin
          if (!shift_busy)   // Last byte fully out
          begin
            done_q <= 1'b1;
            state  <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_fetch && bus_rsp.ack)
      item_q <= '{dc: bus_rsp.rdata[8], data: bus_rsp.rdata[7:0]};
  end

  always_comb
  begin
    bus_req       = '0;
    bus_req.req   = state == st_fetch;
    bus_req.addr  = bus_pkg::addr_t'({addr_q, 2'b00});
  end

  assign item = item_q;
  assign send = state == st_wait_shift && !shift_busy;
  assign busy = state != st_idle;
  assign done = done_q;

endmodule

// ==== source/stream_regs.sv ====
`timescale 1ns/1ns

module stream_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  bus_pkg::bus_req_t        req,
  output bus_pkg::bus_rsp_t        rsp,
  output display_pkg::stream_cfg_t cfg
);

  bus_pkg::word_idx_t  base_q;
  display_pkg::count_t count_q;
  display_pkg::div_t   div_q;
  bus_pkg::data_t      rdata_q;
  bus_pkg::data_t      rd_word;
  logic [27:0]         off;   // Offset within the block, word aligned
  logic                req_q;
  logic                ack_q;
  logic                accept;
  logic                hit_base;
  logic                hit_count;
  logic                hit_div;

  assign off       = {req.addr[27:2], 2'b00};
  assign hit_base  = off == bus_pkg::reg_base_addr[27:0];
  assign hit_count = off == bus_pkg::reg_count_addr[27:0];
  assign hit_div   = off == bus_pkg::reg_div_addr[27:0];
  assign accept    = req.req && !req_q;

  always_comb
  begin
    rd_word = '0;   // Unmapped reads zero
    if (hit_base)
      rd_word = bus_pkg::data_t'(base_q);
    if (hit_count)
      rd_word = bus_pkg::data_t'(count_q);
    if (hit_div)
      rd_word = bus_pkg::data_t'(div_q);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
      base_q  <= '0;
      count_q <= '0;
      div_q   <= display_pkg::div_reset;
    end
    else
    begin
      req_q <= req.req;
      ack_q <= accept;
      if (accept && req.write)
      begin
        if (hit_base)
          base_q <= bus_pkg::word_idx_t'(req.wdata);
        if (hit_count)
          count_q <= display_pkg::count_t'(req.wdata);
        if (hit_div)
          div_q <= display_pkg::div_t'(req.wdata);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      rdata_q <= rd_word;
  end

  assign rsp = '{ack: ack_q, rdata: rdata_q};
  assign cfg = '{base: base_q, count: count_q, div: div_q};

endmodule

// ==== source/word_mem.sv ====
`timescale 1ns/1ns

module word_mem (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp
);

  bus_pkg::data_t     mem [bus_pkg::mem_words];
  bus_pkg::word_idx_t idx;
  bus_pkg::data_t     rdata_q;
  logic               req_q;
  logic               ack_q;
  logic               accept;

  assign idx    = req.addr[11:2];
  assign accept = req.req && !req_q;   // New request only on a rising req

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q <= 1'b0;
      ack_q <= 1'b0;
    end
    else
    begin
      req_q <= req.req;
      ack_q <= accept;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (req.write)
        mem[idx] <= req.wdata;
      rdata_q <= mem[idx];   // Old contents on a write
    end
  end

  assign rsp = '{ack: ack_q, rdata: rdata_q};

  // A master keeps req up until its ack arrives
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req.req && !rsp.ack |=> req.req || rsp.ack);

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
  input  logic              clk,
  input  logic              rst_n,
  input  bus_pkg::bus_req_t host_req,
  output bus_pkg::bus_rsp_t host_rsp,
  input  bus_pkg::bus_req_t strm_req,
  output bus_pkg::bus_rsp_t strm_rsp,
  output bus_pkg::bus_req_t mem_req,
  input  bus_pkg::bus_rsp_t mem_rsp,
  output bus_pkg::bus_req_t reg_req,
  input  bus_pkg::bus_rsp_t reg_rsp
);

  typedef enum logic [1:0] {
    gnt_idle,
    gnt_host,
    gnt_strm
  } grant_t;

  grant_t grant;         // Memory owner
  logic   reg_gnt;       // Host owns the register path
  logic   host_to_reg;

  assign host_to_reg = |(host_req.addr & bus_pkg::reg_base);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      grant   <= gnt_idle;
      reg_gnt <= 1'b0;
    end
    else
    begin
      case (grant)
        gnt_idle:
        begin
          // Host wins a tie
          if (host_req.req && !host_to_reg)
            grant <= gnt_host;
          else if (strm_req.req)
            grant <= gnt_strm;
        end
        default:
        begin
          if (mem_rsp.ack)
            grant <= gnt_idle;   // One idle cycle lets req fall at the slave
        end
      endcase

      // Register traffic never touches the memory grant
      if (reg_gnt)
      begin
        if (reg_rsp.ack)
          reg_gnt <= 1'b0;
      end
      else if (host_req.req && host_to_reg)
        reg_gnt <= 1'b1;
    end
  end

  always_comb
  begin
    mem_req  = '0;
    reg_req  = '0;
    host_rsp = '0;
    strm_rsp = '0;
    case (grant)
      gnt_host: mem_req = host_req;
      gnt_strm: mem_req = strm_req;
      default: ;
    endcase
    if (grant == gnt_host)
      host_rsp = mem_rsp;
    if (grant == gnt_strm)
      strm_rsp = mem_rsp;
    if (reg_gnt)
    begin
      reg_req  = host_req;
      host_rsp = reg_rsp;
    end
  end

  // Each slave ack belongs to exactly one owner of its path
  a_mem_ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp.ack |-> grant != gnt_idle);
  a_reg_ack_owned: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rsp.ack |-> reg_gnt);

endmodule

// ==== source/reset_sync.sv ====
`timescale 1ns/1ns

module reset_sync (
  input  logic clk,
  input  logic arst_n,
  output logic rst_n
);

  logic [2:0] sync;   // Release chain

  // Assert at once, release after three clock edges
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sync <= '0;
    else
      sync <= {sync[1:0], 1'b1};
  end

  assign rst_n = sync[2];

endmodule

// ==== source/display_pkg.sv ====
package display_pkg;

  localparam int div_width = 8;

  // SPI half period minus one, in clk cycles
  typedef logic [div_width-1:0] div_t;
  typedef logic [10:0]          count_t;   // Items per frame

  localparam div_t div_reset = 8'd3;

  // One display byte with its data/command flag
  typedef struct packed {
    logic       dc;
    logic [7:0] data;
  } disp_item_t;

  typedef struct packed {
    bus_pkg::word_idx_t base;
    count_t             count;
    div_t               div;
  } stream_cfg_t;

endpackage

// ==== source/bus_pkg.sv ====
package bus_pkg;

  // Byte address, low two bits ignored by the slaves
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [9:0]  word_idx_t;   // Word index into word_mem

  localparam int mem_words = 1024;

  // Bit 28 selects the register block, everything else is memory
  localparam addr_t reg_base = 32'h1000_0000;

  // Register offsets inside the block
  localparam addr_t reg_base_addr  = 32'h0000_0000;
  localparam addr_t reg_count_addr = 32'h0000_0004;
  localparam addr_t reg_div_addr   = 32'h0000_0008;

  // Master to slave
  typedef struct packed {
    logic  req;
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Slave to master, rdata valid with ack
  typedef struct packed {
    logic  ack;
    data_t rdata;
  } bus_rsp_t;

endpackage
